// ==== src/fe_defines.svh ====
// Front-end sizing. BTB and BHT index fields start at PC bit 2 (32-bit words only)
// FE_RAS_DEPTH must be a power of two
`ifndef FE_DEFINES_SVH
`define FE_DEFINES_SVH

`define FE_VADDR_W   32
`define FE_BTB_IDX_W 4
`define FE_BTB_TAG_W 8
`define FE_BHT_IDX_W 5
`define FE_GHIST_W   4
`define FE_RAS_DEPTH 4

// Fetch starts here after reset
`define FE_BOOT_PC   32'h0000_0100

`endif

// ==== src/fe_pkg.sv ====
// Front-end types. Widths come from the defines header
`include "fe_defines.svh"

package fe_pkg;

  typedef logic [`FE_VADDR_W-1:0]   vaddr_t;
  typedef logic [`FE_BTB_IDX_W-1:0] btb_idx_t;
  typedef logic [`FE_BTB_TAG_W-1:0] btb_tag_t;
  typedef logic [`FE_BHT_IDX_W-1:0] bht_idx_t;
  // Newest outcome in bit 0
  typedef logic [`FE_GHIST_W-1:0]   ghist_t;
  // Upper bit is the prediction
  typedef logic [1:0]               bht_ctr_t;

  ////////////////////////////////////////
  // Pre-decode result
  ////////////////////////////////////////
  typedef struct packed {
    logic        branch;
    logic        jal;
    logic        jalr;
    logic        call;
    logic        ret;
    logic [31:0] imm;
  } fe_scan_s;

  ////////////////////////////////////////
  // Per-fetch branch metadata
  ////////////////////////////////////////
  typedef struct packed {
    logic     src_btb;
    logic     src_ras;
    logic     site_br;
    logic     site_jal;
    logic     site_jalr;
    logic     site_call;
    logic     site_return;
    ghist_t   ghist;
    bht_idx_t bht_idx;
    bht_ctr_t bht_ctr;
    btb_idx_t btb_idx;
    btb_tag_t btb_tag;
    logic     pred_taken;
  } fe_br_meta_s;

endpackage

// ==== src/fe_instr_scan.sv ====
// RV32 base encodings only, no compressed forms
`timescale 1ns/1ps

module fe_instr_scan
  import fe_pkg::*;
(
  input  logic [31:0] instr_i,
  output fe_scan_s    scan_o
);

  logic [6:0] opcode;
  logic [4:0] rd;
  logic [4:0] rs1;
  logic       rd_link;
  logic       rs1_link;

  assign opcode = instr_i[6:0];
  assign rd     = instr_i[11:7];
  assign rs1    = instr_i[19:15];

  // x1 and x5 are the link registers
  assign rd_link  = (rd == 5'd1) || (rd == 5'd5);
  assign rs1_link = (rs1 == 5'd1) || (rs1 == 5'd5);

  assign scan_o.branch = (opcode == 7'b1100011);
  assign scan_o.jal    = (opcode == 7'b1101111);
  assign scan_o.jalr   = (opcode == 7'b1100111);
  assign scan_o.call   = (scan_o.jal || scan_o.jalr) && rd_link;
  assign scan_o.ret    = scan_o.jalr && rs1_link && (rd == 5'd0);

  // B-type for branches, J-type otherwise
  assign scan_o.imm = scan_o.branch
    ? {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0}
    : {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

endmodule

// ==== src/fe_btb.sv ====
// Direct mapped, one read and one write port. A write to the entry being read
// shows up only on the next read
`timescale 1ns/1ps
`include "fe_defines.svh"

module fe_btb
  import fe_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     r_v_i,
  input  vaddr_t   r_addr_i,
  output vaddr_t   br_tgt_o,
  output logic     br_tgt_v_o,
  output logic     br_tgt_jmp_o,
  input  logic     w_v_i,
  input  logic     w_clr_i,
  input  logic     w_jmp_i,
  input  btb_idx_t w_idx_i,
  input  btb_tag_t w_tag_i,
  input  vaddr_t   w_tgt_i
);

  localparam int depth_lp = 2 ** `FE_BTB_IDX_W;

  logic [depth_lp-1:0] valid_r;
  logic [depth_lp-1:0] jmp_r;
  btb_tag_t            tag_mem [depth_lp];
  vaddr_t              tgt_mem [depth_lp];
  btb_idx_t            r_idx;
  btb_tag_t            r_tag;

  assign r_idx = r_addr_i[2 +: `FE_BTB_IDX_W];
  assign r_tag = r_addr_i[2 + `FE_BTB_IDX_W +: `FE_BTB_TAG_W];

  ////////////////////////////////////////
  // Table update
  ////////////////////////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      valid_r <= '0;
    else if (w_v_i)
      valid_r[w_idx_i] <= !w_clr_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (w_v_i && !w_clr_i)
    begin
      jmp_r[w_idx_i]   <= w_jmp_i;
      tag_mem[w_idx_i] <= w_tag_i;
      tgt_mem[w_idx_i] <= w_tgt_i;
    end
  end

  ////////////////////////////////////////
  // Registered lookup, holds without r_v_i
  ////////////////////////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      br_tgt_v_o   <= 1'b0;
      br_tgt_jmp_o <= 1'b0;
    end
    else if (r_v_i)
    begin
      br_tgt_v_o   <= valid_r[r_idx] && (tag_mem[r_idx] == r_tag);
      br_tgt_jmp_o <= valid_r[r_idx] && jmp_r[r_idx];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (r_v_i)
      br_tgt_o <= tgt_mem[r_idx];
  end

endmodule

// ==== src/fe_bht.sv ====
// Gshare table, index is PC[2+] xor zero-extended global history
`timescale 1ns/1ps
`include "fe_defines.svh"

module fe_bht
  import fe_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     r_v_i,
  input  vaddr_t   r_addr_i,
  input  ghist_t   r_ghist_i,
  output bht_ctr_t ctr_o,
  output logic     pred_o,
  output bht_idx_t idx_o,
  input  logic     w_v_i,
  input  bht_idx_t w_idx_i,
  input  bht_ctr_t w_ctr_i,
  input  logic     w_taken_i
);

  localparam int depth_lp = 2 ** `FE_BHT_IDX_W;

  bht_ctr_t ctr_mem [depth_lp];
  bht_idx_t r_idx;
  bht_ctr_t w_ctr_n;

  assign r_idx = r_addr_i[2 +: `FE_BHT_IDX_W] ^ bht_idx_t'(r_ghist_i);

  // Saturating step of the counter that was read at fetch
  always_comb
  begin
    if (w_taken_i)
      w_ctr_n = (w_ctr_i == 2'b11) ? 2'b11 : w_ctr_i + 2'd1;
    else
      w_ctr_n = (w_ctr_i == 2'b00) ? 2'b00 : w_ctr_i - 2'd1;
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      // Weakly not-taken
      for (int i = 0; i < depth_lp; i++)
        ctr_mem[i] <= 2'b01;
      ctr_o <= 2'b01;
      idx_o <= '0;
    end
    else
    begin
      if (w_v_i)
        ctr_mem[w_idx_i] <= w_ctr_n;
      if (r_v_i)
      begin
        ctr_o <= ctr_mem[r_idx];
        idx_o <= r_idx;
      end
    end
  end

  assign pred_o = ctr_o[1];

endmodule

// ==== src/fe_ras.sv ====
// Circular stack. Overflow overwrites the oldest entry, underflow pops nothing
`timescale 1ns/1ps
`include "fe_defines.svh"

module fe_ras
  import fe_pkg::*;
(
  input  logic   clk_i,
  input  logic   arst_n_i,
  input  logic   call_i,
  input  logic   return_i,
  input  vaddr_t addr_i,
  output vaddr_t tgt_o,
  output logic   v_o
);

  localparam int ptr_w_lp = $clog2(`FE_RAS_DEPTH);
  localparam logic [ptr_w_lp:0] full_cnt_lp = `FE_RAS_DEPTH;

  vaddr_t              stack_r [`FE_RAS_DEPTH];
  logic [ptr_w_lp-1:0] top_r;
  logic [ptr_w_lp:0]   cnt_r;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      for (int i = 0; i < `FE_RAS_DEPTH; i++)
        stack_r[i] <= '0;
      top_r <= '0;
      cnt_r <= '0;
    end
    else if (call_i && return_i)
      stack_r[top_r] <= addr_i;
    else if (call_i)
    begin
      stack_r[top_r + 1'b1] <= addr_i;
      top_r <= top_r + 1'b1;
      if (cnt_r != full_cnt_lp)
        cnt_r <= cnt_r + 1'b1;
    end
    else if (return_i && v_o)
    begin
      top_r <= top_r - 1'b1;
      cnt_r <= cnt_r - 1'b1;
    end
  end

  assign tgt_o = stack_r[top_r];
  assign v_o   = (cnt_r != '0);

endmodule

// ==== src/fe_pc_gen.sv ====
// Front end queue always accepts; next_fetch_yumi_i is the only stall
// Redirect and attaboy updates share one BTB and one BHT write port
`timescale 1ns/1ps
`include "fe_defines.svh"

module fe_pc_gen
  import fe_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        redirect_v_i,
  input  vaddr_t      redirect_pc_i,
  input  logic        redirect_br_v_i,
  input  logic        redirect_br_taken_i,
  input  logic        redirect_br_nonbr_i,
  input  fe_br_meta_s redirect_meta_i,
  output vaddr_t      next_fetch_o,
  input  logic        next_fetch_yumi_i,
  input  logic [31:0] fetch_i,
  input  logic        fetch_v_i,
  output logic [31:0] fetch_instr_o,
  output logic        fetch_instr_v_o,
  output vaddr_t      fetch_pc_o,
  output fe_br_meta_s fetch_meta_o,
  output logic        ovr_o,
  input  logic        attaboy_v_i,
  input  vaddr_t      attaboy_pc_i,
  input  logic        attaboy_taken_i,
  input  fe_br_meta_s attaboy_meta_i,
  output logic        attaboy_yumi_o,
  output logic [31:0] fetch_to_scan_o,
  input  fe_scan_s    scan_i,
  input  vaddr_t      btb_tgt_i,
  input  logic        btb_tgt_v_i,
  input  logic        btb_jmp_i,
  output logic        btb_w_v_o,
  output logic        btb_w_clr_o,
  output logic        btb_w_jmp_o,
  output btb_idx_t    btb_w_idx_o,
  output btb_tag_t    btb_w_tag_o,
  output vaddr_t      btb_w_tgt_o,
  output ghist_t      bht_r_ghist_o,
  input  bht_ctr_t    bht_ctr_i,
  input  logic        bht_pred_i,
  input  bht_idx_t    bht_idx_i,
  output logic        bht_w_v_o,
  output bht_idx_t    bht_w_idx_o,
  output bht_ctr_t    bht_w_ctr_o,
  output logic        bht_w_taken_o,
  output logic        ras_call_o,
  output logic        ras_return_o,
  output vaddr_t      ras_addr_o,
  input  vaddr_t      ras_tgt_i,
  input  logic        ras_v_i
);

  logic        if1_v_r, if2_v_r;
  vaddr_t      if1_pc_r, if2_pc_r;
  fe_br_meta_s if1_meta_r, if2_meta_r, if1_meta, next_meta;
  ghist_t      ghist_r, ghist_n;
  vaddr_t      br_tgt;
  logic        ovr_jmp, ovr_br, ovr_ret;
  logic        btb_taken, if2_adv;
  logic        redir_btb_w, redir_btb_clr, redir_bht_w, redir_busy;

  ////////////////////////////////////////
  // Next PC, priority order
  ////////////////////////////////////////
  assign btb_taken = btb_tgt_v_i && (bht_pred_i || btb_jmp_i);

  always_comb
  begin
    next_meta       = '0;
    next_meta.ghist = ghist_n;
    if (redirect_v_i)
      next_fetch_o = redirect_pc_i;
    else if (ovr_o)
    begin
      next_fetch_o      = ovr_ret ? ras_tgt_i : br_tgt;
      next_meta.src_ras = ovr_ret;
    end
    else if (!if1_v_r)
      // Retry a PC that was redirected to but not yet accepted
      next_fetch_o = if1_pc_r;
    else if (btb_taken)
      next_fetch_o = btb_tgt_i;
    else
      next_fetch_o = if1_pc_r + 32'd4;
  end

  // BTB/BHT read results join the metadata in IF1
  always_comb
  begin
    if1_meta            = if1_meta_r;
    if1_meta.src_btb    = btb_tgt_v_i;
    if1_meta.bht_ctr    = bht_ctr_i;
    if1_meta.bht_idx    = bht_idx_i;
    if1_meta.btb_idx    = if1_pc_r[2 +: `FE_BTB_IDX_W];
    if1_meta.btb_tag    = if1_pc_r[2 + `FE_BTB_IDX_W +: `FE_BTB_TAG_W];
    if1_meta.pred_taken = bht_pred_i;
  end

  ////////////////////////////////////////
  // Stage registers
  ////////////////////////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      if1_v_r  <= 1'b0;
      if1_pc_r <= `FE_BOOT_PC;
      if2_v_r  <= 1'b0;
      ghist_r  <= '0;
    end
    else
    begin
      ghist_r <= ghist_n;
      if (redirect_v_i || next_fetch_yumi_i)
      begin
        if1_v_r  <= next_fetch_yumi_i;
        if1_pc_r <= next_fetch_o;
      end
      if (redirect_v_i)
        if2_v_r <= 1'b0;
      else if (next_fetch_yumi_i)
        // An override kills the wrong-path PC in IF1
        if2_v_r <= if1_v_r && !ovr_o;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (redirect_v_i || next_fetch_yumi_i)
      if1_meta_r <= next_meta;
    if (next_fetch_yumi_i)
    begin
      if2_pc_r   <= if1_pc_r;
      if2_meta_r <= if1_meta;
    end
  end

  ////////////////////////////////////////
  // IF2 scan and override
  ////////////////////////////////////////
  assign fetch_to_scan_o = fetch_i;
  assign fetch_instr_o   = fetch_i;
  assign fetch_instr_v_o = fetch_v_i && if2_v_r;
  assign fetch_pc_o      = if2_pc_r;
  assign br_tgt          = if2_pc_r + scan_i.imm;

  always_comb
  begin
    fetch_meta_o             = if2_meta_r;
    fetch_meta_o.site_br     = fetch_instr_v_o && scan_i.branch;
    fetch_meta_o.site_jal    = fetch_instr_v_o && scan_i.jal;
    fetch_meta_o.site_jalr   = fetch_instr_v_o && scan_i.jalr;
    fetch_meta_o.site_call   = fetch_instr_v_o && scan_i.call;
    fetch_meta_o.site_return = fetch_instr_v_o && scan_i.ret;
  end

  assign ovr_jmp = fetch_meta_o.site_jal && (if1_pc_r != br_tgt);
  assign ovr_br  = fetch_meta_o.site_br && if2_meta_r.pred_taken && (if1_pc_r != br_tgt);
  assign ovr_ret = fetch_meta_o.site_return && ras_v_i && (if1_pc_r != ras_tgt_i);
  assign ovr_o   = ovr_jmp || ovr_br || ovr_ret;

  // IF2 leaves the pipe this cycle
  assign if2_adv = next_fetch_yumi_i && !redirect_v_i && fetch_instr_v_o;

  assign ras_call_o   = if2_adv && scan_i.call;
  assign ras_return_o = if2_adv && scan_i.ret;
  assign ras_addr_o   = if2_pc_r + 32'd4;

  // Restore on redirect, else shift in the IF2 branch direction
  assign ghist_n = redirect_br_v_i ? redirect_meta_i.ghist
    : (if2_adv && scan_i.branch) ? {ghist_r[`FE_GHIST_W-2:0], if2_meta_r.pred_taken}
    : ghist_r;
  assign bht_r_ghist_o = ghist_n;

  ////////////////////////////////////////
  // Update arbitration, redirect first
  ////////////////////////////////////////
  assign redir_btb_w   = redirect_br_v_i && redirect_br_taken_i;
  assign redir_btb_clr = redirect_br_v_i && redirect_br_nonbr_i && redirect_meta_i.src_btb;
  assign redir_bht_w   = redirect_br_v_i && redirect_meta_i.site_br;
  assign redir_busy    = redir_btb_w || redir_btb_clr || redir_bht_w;

  assign attaboy_yumi_o = attaboy_v_i && !redir_busy;

  assign btb_w_v_o   = redir_btb_w || redir_btb_clr
    || (attaboy_yumi_o && attaboy_taken_i && !attaboy_meta_i.src_btb);
  assign btb_w_clr_o = redir_btb_clr && !redir_btb_w;
  assign btb_w_jmp_o = redir_busy
    ? (redirect_meta_i.site_jal || redirect_meta_i.site_jalr)
    : (attaboy_meta_i.site_jal || attaboy_meta_i.site_jalr);
  assign btb_w_idx_o = redir_busy ? redirect_meta_i.btb_idx : attaboy_meta_i.btb_idx;
  assign btb_w_tag_o = redir_busy ? redirect_meta_i.btb_tag : attaboy_meta_i.btb_tag;
  assign btb_w_tgt_o = redir_busy ? redirect_pc_i : attaboy_pc_i;

  assign bht_w_v_o     = redir_bht_w || (attaboy_yumi_o && attaboy_meta_i.site_br);
  assign bht_w_idx_o   = redir_busy ? redirect_meta_i.bht_idx : attaboy_meta_i.bht_idx;
  assign bht_w_ctr_o   = redir_busy ? redirect_meta_i.bht_ctr : attaboy_meta_i.bht_ctr;
  assign bht_w_taken_o = redir_busy ? redirect_br_taken_i : attaboy_taken_i;

endmodule

// ==== src/fe_top.sv ====
// Fetch front end. The fetched word must come back in the cycle its PC is in IF2
`timescale 1ns/1ps

module fe_top
  import fe_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        redirect_v_i,
  input  vaddr_t      redirect_pc_i,
  input  logic        redirect_br_v_i,
  input  logic        redirect_br_taken_i,
  input  logic        redirect_br_nonbr_i,
  input  fe_br_meta_s redirect_meta_i,
  output vaddr_t      next_fetch_o,
  input  logic        next_fetch_yumi_i,
  input  logic [31:0] fetch_i,
  input  logic        fetch_v_i,
  output logic [31:0] fetch_instr_o,
  output logic        fetch_instr_v_o,
  output vaddr_t      fetch_pc_o,
  output fe_br_meta_s fetch_meta_o,
  output logic        ovr_o,
  input  logic        attaboy_v_i,
  input  vaddr_t      attaboy_pc_i,
  input  logic        attaboy_taken_i,
  input  fe_br_meta_s attaboy_meta_i,
  output logic        attaboy_yumi_o
);

  logic [31:0] scan_word;
  fe_scan_s    scan;
  vaddr_t      btb_tgt, btb_w_tgt;
  logic        btb_tgt_v, btb_jmp;
  logic        btb_w_v, btb_w_clr, btb_w_jmp;
  btb_idx_t    btb_w_idx;
  btb_tag_t    btb_w_tag;
  ghist_t      bht_ghist;
  bht_ctr_t    bht_ctr, bht_w_ctr;
  bht_idx_t    bht_idx, bht_w_idx;
  logic        bht_pred, bht_w_v, bht_w_taken;
  logic        ras_call, ras_return, ras_v;
  vaddr_t      ras_addr, ras_tgt;

  fe_instr_scan u_scan (.instr_i(scan_word), .scan_o(scan));

  // Both tables are read with the PC being handed out
  fe_btb u_btb (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .r_v_i       (next_fetch_yumi_i),
    .r_addr_i    (next_fetch_o),
    .br_tgt_o    (btb_tgt),
    .br_tgt_v_o  (btb_tgt_v),
    .br_tgt_jmp_o(btb_jmp),
    .w_v_i       (btb_w_v),
    .w_clr_i     (btb_w_clr),
    .w_jmp_i     (btb_w_jmp),
    .w_idx_i     (btb_w_idx),
    .w_tag_i     (btb_w_tag),
    .w_tgt_i     (btb_w_tgt)
  );

  fe_bht u_bht (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .r_v_i    (next_fetch_yumi_i),
    .r_addr_i (next_fetch_o),
    .r_ghist_i(bht_ghist),
    .ctr_o    (bht_ctr),
    .pred_o   (bht_pred),
    .idx_o    (bht_idx),
    .w_v_i    (bht_w_v),
    .w_idx_i  (bht_w_idx),
    .w_ctr_i  (bht_w_ctr),
    .w_taken_i(bht_w_taken)
  );

  fe_ras u_ras (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .call_i  (ras_call),
    .return_i(ras_return),
    .addr_i  (ras_addr),
    .tgt_o   (ras_tgt),
    .v_o     (ras_v)
  );

  // External ports connect by name
  fe_pc_gen u_pc_gen (
    .fetch_to_scan_o(scan_word),
    .scan_i         (scan),
    .btb_tgt_i      (btb_tgt),
    .btb_tgt_v_i    (btb_tgt_v),
    .btb_jmp_i      (btb_jmp),
    .btb_w_v_o      (btb_w_v),
    .btb_w_clr_o    (btb_w_clr),
    .btb_w_jmp_o    (btb_w_jmp),
    .btb_w_idx_o    (btb_w_idx),
    .btb_w_tag_o    (btb_w_tag),
    .btb_w_tgt_o    (btb_w_tgt),
    .bht_r_ghist_o  (bht_ghist),
    .bht_ctr_i      (bht_ctr),
    .bht_pred_i     (bht_pred),
    .bht_idx_i      (bht_idx),
    .bht_w_v_o      (bht_w_v),
    .bht_w_idx_o    (bht_w_idx),
    .bht_w_ctr_o    (bht_w_ctr),
    .bht_w_taken_o  (bht_w_taken),
    .ras_call_o     (ras_call),
    .ras_return_o   (ras_return),
    .ras_addr_o     (ras_addr),
    .ras_tgt_i      (ras_tgt),
    .ras_v_i        (ras_v),
    .*
  );

endmodule

// ==== verification/fe_tb.sv ====
// Front-end testbench. Instruction memory covers 64 words from the boot PC
// and returns the word at fetch_pc_o in the same cycle
`timescale 1ns/1ps
`include "fe_defines.svh"

module fe_tb
  import fe_pkg::*;
();

  localparam int test_cycles_lp = 200;
  localparam int wd_cycles_lp   = 2 * test_cycles_lp;
  localparam int max_wait_lp    = 40;

  logic        clk_i, arst_n_i;
  logic        redirect_v_i, redirect_br_v_i, redirect_br_taken_i, redirect_br_nonbr_i;
  vaddr_t      redirect_pc_i, next_fetch_o, fetch_pc_o, attaboy_pc_i;
  fe_br_meta_s redirect_meta_i, fetch_meta_o, attaboy_meta_i, meta_q;
  logic        next_fetch_yumi_i, fetch_v_i, fetch_instr_v_o, ovr_o;
  logic [31:0] fetch_i, fetch_instr_o;
  logic        attaboy_v_i, attaboy_taken_i, attaboy_yumi_o;

  logic [31:0] imem [64];
  vaddr_t      acc [$];
  vaddr_t      prev_next;
  logic        prev_stall;
  logic [31:0] lcg_state;
  int          n;

  fe_top DUT (.*);

  ////////////////////////////////////////
  // Clock, watchdog, memory model
  ////////////////////////////////////////
  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial
  begin
    repeat (wd_cycles_lp) @(posedge clk_i);
    $display("Watchdog expired, the tests did not finish in %0d cycles", wd_cycles_lp);
    $display("Testbench failed");
    $fatal(1);
  end

  function automatic logic [31:0] read_imem(vaddr_t pc);
    if (pc >= `FE_BOOT_PC && pc < `FE_BOOT_PC + 32'd256)
      return imem[(pc - `FE_BOOT_PC) >> 2];
    return 32'h0000_0013;
  endfunction

  always_comb
    fetch_i = read_imem(fetch_pc_o);

  // RV32 encodings
  function automatic logic [31:0] enc_jal(logic [4:0] rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] enc_beq(logic [12:0] off);
    return {off[12], off[10:5], 5'd0, 5'd0, 3'b000, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  ////////////////////////////////////////
  // Failure reporting
  ////////////////////////////////////////
  task automatic fail_value(string name, logic [31:0] exp, logic [31:0] act);
    $display("error: %s expected %h actual %h", name, exp, act);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic fail_text(string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1);
  endtask

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    redirect_v_i |-> next_fetch_o == redirect_pc_i)
    else fail_value("redirect_pc", $sampled(redirect_pc_i), $sampled(next_fetch_o));

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (attaboy_v_i && !redirect_v_i) |-> attaboy_yumi_o)
    else fail_value("attaboy_yumi", 1, $sampled(attaboy_yumi_o));

  ////////////////////////////////////////
  // Cycle drivers
  ////////////////////////////////////////
  // Sample mid-cycle, then log the PC handed out at the next edge
  task automatic check_cycle();
    #1;
    if (prev_stall && !redirect_v_i)
      assert (next_fetch_o == prev_next) else fail_value("hold", prev_next, next_fetch_o);
    if (fetch_instr_v_o)
    begin
      assert (acc.size() >= 2)
        else fail_text("IF2 was valid before its PC had passed through IF1");
      assert (fetch_pc_o == acc[$-1]) else fail_value("if2_pc", acc[$-1], fetch_pc_o);
      assert (fetch_instr_o == read_imem(fetch_pc_o))
        else fail_value("fetch_instr", read_imem(fetch_pc_o), fetch_instr_o);
    end
    if (redirect_v_i)
      acc.delete();
    else if (ovr_o && next_fetch_yumi_i)
      // The override kills the wrong-path PC in IF1
      void'(acc.pop_back());
    if (next_fetch_yumi_i)
      acc.push_back(next_fetch_o);
    prev_stall = !next_fetch_yumi_i && !redirect_v_i;
    prev_next  = next_fetch_o;
  endtask

  task automatic step(logic yumi);
    @(negedge clk_i);
    redirect_v_i      = 1'b0;
    redirect_br_v_i   = 1'b0;
    attaboy_v_i       = 1'b0;
    next_fetch_yumi_i = yumi;
    check_cycle();
  endtask

  task automatic redirect_to(vaddr_t pc, logic br_v, logic taken, fe_br_meta_s meta);
    @(negedge clk_i);
    redirect_v_i        = 1'b1;
    redirect_pc_i       = pc;
    redirect_br_v_i     = br_v;
    redirect_br_taken_i = taken;
    redirect_meta_i     = meta;
    attaboy_v_i         = 1'b0;
    next_fetch_yumi_i   = 1'b1;
    check_cycle();
  endtask

  task automatic send_attaboy(vaddr_t pc, fe_br_meta_s meta);
    @(negedge clk_i);
    redirect_v_i      = 1'b0;
    redirect_br_v_i   = 1'b0;
    attaboy_v_i       = 1'b1;
    attaboy_pc_i      = pc;
    attaboy_taken_i   = 1'b1;
    attaboy_meta_i    = meta;
    next_fetch_yumi_i = 1'b1;
    check_cycle();
  endtask

  task automatic run_until_if2(vaddr_t pc);
    int i;
    i = 0;
    step(1'b1);
    while (!(fetch_instr_v_o && fetch_pc_o == pc))
    begin
      i++;
      if (i > max_wait_lp)
        fail_text($sformatf("PC %h never reached IF2", pc));
      step(1'b1);
    end
  endtask

  task automatic run_until_accepted(vaddr_t pc);
    int i;
    i = 0;
    step(1'b1);
    while (acc.size() == 0 || acc[$] != pc)
    begin
      i++;
      if (i > max_wait_lp)
        fail_text($sformatf("PC %h was never accepted", pc));
      step(1'b1);
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  initial
  begin
    lcg_state = 32'h44ab;
    for (int i = 0; i < 64; i++)
      imem[i] = {12'(`FE_BOOT_PC + 4 * i), 5'd0, 3'd0, 5'd0, 7'h13};
    imem[(32'h140 - `FE_BOOT_PC) >> 2] = enc_jal(5'd0, 21'h40);
    imem[(32'h188 - `FE_BOOT_PC) >> 2] = enc_jal(5'd1, 21'h38);
    imem[(32'h1c4 - `FE_BOOT_PC) >> 2] = {12'd0, 5'd1, 3'd0, 5'd0, 7'b1100111};
    imem[(32'h190 - `FE_BOOT_PC) >> 2] = enc_beq(13'h20);

    arst_n_i = 1'b0;
    fetch_v_i = 1'b1;
    next_fetch_yumi_i = 1'b0;
    redirect_v_i = 1'b0;
    redirect_pc_i = '0;
    redirect_br_v_i = 1'b0;
    redirect_br_taken_i = 1'b0;
    redirect_br_nonbr_i = 1'b0;
    redirect_meta_i = '0;
    attaboy_v_i = 1'b0;
    attaboy_pc_i = '0;
    attaboy_taken_i = 1'b0;
    attaboy_meta_i = '0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    #1;
    assert (next_fetch_o == `FE_BOOT_PC) else fail_value("boot_pc", `FE_BOOT_PC, next_fetch_o);
    prev_next  = next_fetch_o;
    prev_stall = 1'b1;

    // Straight-line code with random stalls
    n = 0;
    while (acc.size() == 0 || acc[$] < 32'h130)
    begin
      step((next_rand() >> 16) % 4 != 0);
      if (next_fetch_yumi_i && acc.size() >= 2)
        assert (acc[$] == acc[$-1] + 32'd4) else fail_value("sequential", acc[$-1] + 4, acc[$]);
      n++;
      if (n > 2 * max_wait_lp)
        fail_text("Sequential fetch did not advance");
    end

    // Jal on a cold BTB
    run_until_if2(32'h140);
    assert (ovr_o) else fail_value("jal_override", 1, ovr_o);
    assert (next_fetch_o == 32'h180) else fail_value("jal_target", 32'h180, next_fetch_o);
    meta_q = fetch_meta_o;

    // Resolved jal trains the BTB
    redirect_to(32'h180, 1'b1, 1'b1, meta_q);
    n = 0;
    while (!fetch_instr_v_o)
    begin
      step(1'b1);
      n++;
      if (n > max_wait_lp)
        fail_text("No valid fetch after the redirect");
    end
    assert (fetch_pc_o == 32'h180) else fail_value("redirect_if2", 32'h180, fetch_pc_o);

    redirect_to(32'h134, 1'b0, 1'b0, '0);
    run_until_accepted(32'h140);
    step(1'b1);
    assert (next_fetch_o == 32'h180) else fail_value("btb_hit", 32'h180, next_fetch_o);
    run_until_if2(32'h140);
    assert (!ovr_o) else fail_value("btb_no_ovr", 0, ovr_o);

    // Call at 0x188, return at 0x1c4
    run_until_if2(32'h1c4);
    assert (ovr_o) else fail_value("ras_return_ovr", 1, ovr_o);
    assert (next_fetch_o == 32'h18c) else fail_value("ras_return", 32'h18c, next_fetch_o);

    // Branch learning with the history restored to zero before each pass
    run_until_if2(32'h190);
    assert (fetch_meta_o.site_br) else fail_value("branch_site", 1, fetch_meta_o.site_br);
    send_attaboy(32'h1b0, fetch_meta_o);
    redirect_to(32'h18c, 1'b1, 1'b0, '0);
    run_until_if2(32'h190);
    send_attaboy(32'h1b0, fetch_meta_o);
    redirect_to(32'h18c, 1'b1, 1'b0, '0);
    run_until_accepted(32'h190);
    step(1'b1);
    assert (next_fetch_o == 32'h1b0) else fail_value("bht_taken", 32'h1b0, next_fetch_o);
    run_until_if2(32'h190);
    assert (fetch_meta_o.bht_ctr == 2'b11)
      else fail_value("bht_ctr", 32'h3, fetch_meta_o.bht_ctr);

    step(1'b0);
    $display("Testbench passed");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+src
src/fe_pkg.sv
src/fe_instr_scan.sv
src/fe_btb.sv
src/fe_bht.sv
src/fe_ras.sv
src/fe_pc_gen.sv
src/fe_top.sv
verification/fe_tb.sv
